// File: bench/cpu_cases.txt
// per case: words, sw, leds, halt address, stores, pixels, then the program words,
// then store pairs (address, data), then pixel pairs (address, value); 0 ends the list
// alu: r1=5 r2=3 r3=r1-r2-1 r4=r1<<r2, store r3 at 18 and r4 at 20
8 0 0 7 2 0
6205 6403 B651 C63F B855 7018 7020 0000
18 1
20 28
// memory round trip: store 1a5 at 8, load it back, store it again at 10
5 0 0 4 2 0
63A5 7008 8408 7010 0000
8 1A5
10 1A5
// control flow: taken branch, branch not taken, jump; only the store at 9 runs
8 0 0 7 1 0
6201 2201 7008 2401 7009 4007 700A 0000
9 1
// pixel at r3 = 55 with value 1
3 0 0 2 0 1
6655 50C1 0000
55 1
// switches: r7 = r0 shows on the LEDs
2 2 2 1 0 0
BE00 0000
0

// File: bench/tb_checker.sv
`timescale 1ns/1ns

module tb_checker (
  input  logic        clk,
  input  logic        reset,
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic        wb_we,
  input  logic        wb_ack,
  input  logic [15:0] wb_adr,
  input  logic [31:0] wb_dat_w,
  input  logic        pixel_en,
  input  logic [31:0] pixel_addr,
  input  logic        pixel_value,
  input  logic [9:0]  leds,
  input  logic        halt
);

  string       test_name;
  logic [9:0]  exp_leds;
  logic [15:0] exp_halt_adr;
  logic [15:0] last_fetch;
  logic        halt_prev;
  logic [15:0] store_adr_q[$];
  logic [31:0] store_dat_q[$];
  logic [31:0] pixel_adr_q[$];
  logic        pixel_val_q[$];
  int          value_errors;
  int          other_errors;

  initial begin
    value_errors = 0;
    other_errors = 0;
    halt_prev    = 1'b0;
    last_fetch   = '0;
  end

  function automatic void start_case(input string name, input logic [9:0] l,
                                     input logic [15:0] halt_adr);
    test_name    = name;
    exp_leds     = l;
    exp_halt_adr = halt_adr;
    store_adr_q.delete();
    store_dat_q.delete();
    pixel_adr_q.delete();
    pixel_val_q.delete();
  endfunction

  function automatic void expect_store(input logic [15:0] a, input logic [31:0] d);
    store_adr_q.push_back(a);
    store_dat_q.push_back(d);
  endfunction

  function automatic void expect_pixel(input logic [31:0] a, input logic v);
    pixel_adr_q.push_back(a);
    pixel_val_q.push_back(v);
  endfunction

  function automatic void compare(input string what, input logic [31:0] exp,
                                  input logic [31:0] act);
    if (exp !== act) begin
      $display("error %s %s: expected %h actual %h", test_name, what, exp, act);
      value_errors++;
    end
  endfunction

  // called once the core has sat halted for a few cycles
  function automatic void end_case();
    compare("leds", {22'h0, exp_leds}, {22'h0, leds});
    compare("halt address", {16'h0, exp_halt_adr}, {16'h0, last_fetch});
    if (store_adr_q.size() != 0) begin
      $display("%s: %0d expected stores never happened", test_name, store_adr_q.size());
      other_errors++;
    end
    if (pixel_adr_q.size() != 0) begin
      $display("%s: %0d expected pixel writes never happened", test_name, pixel_adr_q.size());
      other_errors++;
    end
  endfunction

  always @(posedge clk) begin
    halt_prev <= halt;
    if (!reset) begin
      if (halt_prev && !halt) begin
        $display("%s: halt fell without a reset", test_name);
        other_errors++;
      end
      if (wb_stb !== wb_cyc) begin
        $display("%s: wb_stb does not follow wb_cyc", test_name);
        other_errors++;
      end
      if (halt && wb_cyc) begin
        $display("%s: a bus cycle started after halt", test_name);
        other_errors++;
      end
      if (wb_cyc && wb_ack && wb_we) begin
        if (store_adr_q.size() == 0) begin
          $display("%s: unexpected store to address %h", test_name, wb_adr);
          other_errors++;
        end else begin
          compare("store address", {16'h0, store_adr_q.pop_front()}, {16'h0, wb_adr});
          compare("store data", store_dat_q.pop_front(), wb_dat_w);
        end
      end
      if (wb_cyc && wb_ack && !wb_we) last_fetch <= wb_adr;  // halt is the last word read
      if (pixel_en) begin
        if (pixel_adr_q.size() == 0) begin
          $display("%s: unexpected pixel strobe at %h", test_name, pixel_addr);
          other_errors++;
        end else begin
          compare("pixel address", pixel_adr_q.pop_front(), pixel_addr);
          compare("pixel value", {31'h0, pixel_val_q.pop_front()}, {31'h0, pixel_value});
        end
      end
    end
  end

endmodule

// File: bench/tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
  input  logic restart,
  output logic clk,
  output logic reset
);

  int cnt;

  initial begin
    clk   = 1'b0;
    reset = 1'b1;
    cnt   = 5;
  end

  always #5 clk = ~clk;  // 10 ns period

  // reset stays high for five rising edges, at start and after each restart
  always @(posedge clk) begin
    if (restart) begin
      reset <= 1'b1;
      cnt   <= 5;
    end else if (cnt != 0) begin
      cnt <= cnt - 1;
      if (cnt == 1) reset <= 1'b0;
    end
  end

endmodule

// File: bench/tb_top.sv
`timescale 1ns/1ns

module tb_top;

  logic        clk, reset, restart;
  logic        wb_cyc, wb_stb, wb_we, wb_ack;
  logic [15:0] wb_adr;
  logic [31:0] wb_dat_w, wb_dat_r;
  logic [1:0]  sw;
  logic [9:0]  leds;
  logic        pixel_en, pixel_value, halt;
  logic [31:0] pixel_addr;

  logic [31:0] mem [65536];
  logic [31:0] cases_mem [256];
  logic [15:0] lfsr;
  logic        pending;
  int          ack_wait;
  int          limit;
  int          cycles;
  string       names [5] = '{"alu", "mem_round_trip", "control_flow", "pixel", "switch_leds"};

  tb_clock i_clock (.restart(restart), .clk(clk), .reset(reset));

  cpu_top i_dut (
    .clk(clk), .reset(reset), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
    .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack), .sw(sw),
    .leds(leds), .pixel_en(pixel_en), .pixel_value(pixel_value), .pixel_addr(pixel_addr),
    .halt(halt)
  );

  tb_checker i_checker (
    .clk(clk), .reset(reset), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
    .wb_ack(wb_ack), .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .pixel_en(pixel_en),
    .pixel_addr(pixel_addr), .pixel_value(pixel_value), .leds(leds), .halt(halt)
  );

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // two LFSR bits give a wait of 0 to 3 cycles
  task automatic draw_delay(output int d);
    d = 0;
    for (int i = 0; i < 2; i++) begin
      lfsr = lfsr_next(lfsr);
      d = (d << 1) | int'(lfsr[0]);
    end
  endtask

  always @(posedge clk) begin
    #1;
    if (reset) begin
      wb_ack  = 1'b0;
      pending = 1'b0;
    end else if (wb_ack) begin
      wb_ack  = 1'b0;
      pending = 1'b0;
    end else if (wb_cyc && wb_stb) begin
      if (!pending) begin
        pending = 1'b1;
        draw_delay(ack_wait);
      end
      if (ack_wait == 0) begin
        if (wb_we) mem[wb_adr] = wb_dat_w;
        wb_dat_r = mem[wb_adr];
        wb_ack   = 1'b1;
      end else begin
        ack_wait--;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (limit != 0 && cycles > limit) begin
      $display("timeout: the DUT did not finish within %0d cycles", limit);
      $display("errors: %0d wrong values, %0d other failures",
               i_checker.value_errors, i_checker.other_errors);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  initial begin
    int p;
    int n;
    int idx;
    sw       = 2'b00;
    wb_ack   = 1'b0;
    wb_dat_r = '0;
    restart  = 1'b0;
    pending  = 1'b0;
    ack_wait = 0;
    lfsr     = 16'd15274;
    cycles   = 0;
    limit    = 0;
    for (int i = 0; i < 256; i++) cases_mem[i] = '0;
    $readmemh("bench/cpu_cases.txt", cases_mem);

    // each case header is: words, sw, leds, halt address, stores, pixels
    p = 0;
    while (cases_mem[p] != 0) begin
      limit += 40 * int'(cases_mem[p]);
      p += 6 + int'(cases_mem[p]) + 2 * int'(cases_mem[p+4]) + 2 * int'(cases_mem[p+5]);
    end

    p   = 0;
    idx = 0;
    while (cases_mem[p] != 0) begin
      n = int'(cases_mem[p]);
      for (int a = 0; a < 65536; a++) mem[a] = {a[15:0], 16'h0000};  // empty words halt
      for (int i = 0; i < n; i++) mem[i] = cases_mem[p+6+i];
      sw = cases_mem[p+1][1:0];
      i_checker.start_case(names[idx], cases_mem[p+2][9:0], cases_mem[p+3][15:0]);
      for (int i = 0; i < int'(cases_mem[p+4]); i++) begin
        i_checker.expect_store(cases_mem[p+6+n+2*i][15:0], cases_mem[p+7+n+2*i]);
      end
      for (int i = 0; i < int'(cases_mem[p+5]); i++) begin
        i_checker.expect_pixel(cases_mem[p+6+n+2*int'(cases_mem[p+4])+2*i],
                               cases_mem[p+7+n+2*int'(cases_mem[p+4])+2*i][0]);
      end
      @(posedge clk);
      #1 restart = 1'b1;
      @(posedge clk);
      #1 restart = 1'b0;
      wait (reset == 1'b0);
      @(posedge clk);
      while (!halt) @(posedge clk);
      repeat (5) @(posedge clk);  // the core must stay quiet here
      #1 i_checker.end_case();
      p += 6 + n + 2 * int'(cases_mem[p+4]) + 2 * int'(cases_mem[p+5]);
      idx++;
    end

    $display("errors: %0d wrong values, %0d other failures",
             i_checker.value_errors, i_checker.other_errors);
    if (i_checker.value_errors == 0 && i_checker.other_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: run.sh
#!/bin/sh
# build with Verilator, run, and decide pass or fail from the output
verilator --binary --timing --assert --top-module tb_top -f src.f -o tb_sim \
  && ./obj_dir/tb_sim | tee /dev/stderr | grep -q "^PASS: all tests$" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// File: src.f
src/cpu_pkg.sv
src/reg_file.sv
src/alu.sv
src/fetch.sv
src/bus_master.sv
src/core_control.sv
src/decode.sv
src/cpu_top.sv
bench/tb_clock.sv
bench/tb_checker.sv
bench/tb_top.sv

// File: src/alu.sv
`timescale 1ns/1ns

module alu (
  input  cpu_pkg::alu_op_t                op,
  input  logic [cpu_pkg::data_width-1:0]  a,
  input  logic [cpu_pkg::data_width-1:0]  b,
  output logic [cpu_pkg::data_width-1:0]  result,
  output logic                            zero
);
  import cpu_pkg::*;

  logic [4:0] shamt;

  assign shamt = b[4:0];  // only the low five bits shift

  always_comb begin
    case (op)
      alu_add:  result = a + b;
      alu_sub:  result = a - b;
      alu_and:  result = a & b;
      alu_or:   result = a | b;
      alu_xor:  result = a ^ b;
      alu_shl:  result = a << shamt;
      alu_shr:  result = a >> shamt;
      alu_slt: begin
        // signed compare, result is 0 or 1
        result = {{(data_width-1){1'b0}}, $signed(a) < $signed(b)};
      end
      alu_nor:  result = ~(a | b);
      alu_sra:  result = $unsigned($signed(a) >>> shamt);
      alu_nand: result = ~(a & b);
      alu_xnor: result = ~(a ^ b);
      alu_seq:  result = {{(data_width-1){1'b0}}, a == b};
      alu_mov, alu_pass_a: begin
        result = a;
      end
      default:  result = b;  // alu_pass_b, used by load immediate
    endcase
  end

  // branches look at this with the pass_a operation on rd
  assign zero = (result == '0);

endmodule

// File: src/bus_master.sv
`timescale 1ns/1ns

module bus_master (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            req_fetch,
  input  logic                            req_data,
  input  logic                            data_we,
  input  logic [cpu_pkg::addr_width-1:0]  pc,
  input  logic [cpu_pkg::addr_width-1:0]  data_adr,
  input  logic [cpu_pkg::data_width-1:0]  wdata,
  output logic                            wb_cyc,
  output logic                            wb_stb,
  output logic                            wb_we,
  output logic [cpu_pkg::addr_width-1:0]  wb_adr,
  output logic [cpu_pkg::data_width-1:0]  wb_dat_w,
  input  logic [cpu_pkg::data_width-1:0]  wb_dat_r,
  input  logic                            wb_ack,
  output logic [cpu_pkg::data_width-1:0]  rdata,
  output logic                            done
);

  logic start;
  logic finish;

  // no new cycle in the done cycle, the requester still holds its request there
  assign start  = (req_fetch | req_data) & ~wb_cyc & ~done;
  assign finish = wb_cyc & wb_ack;

  assign wb_stb = wb_cyc;  // classic single transfers, strobe follows cycle

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_cyc <= 1'b0;
      wb_we  <= 1'b0;
      done   <= 1'b0;
    end else begin
      done <= finish;
      if (start) begin
        wb_cyc <= 1'b1;
        wb_we  <= req_data & data_we;
      end else if (finish) begin
        wb_cyc <= 1'b0;
        wb_we  <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      wb_adr   <= req_data ? data_adr : pc;
      wb_dat_w <= wdata;
    end
    // held until the next read, so a load result survives into writeback
    if (finish && !wb_we) rdata <= wb_dat_r;
  end

  // the slave may stall for any number of cycles and still sees one address
  assert property (@(posedge clk) disable iff (reset) (wb_stb && !wb_ack) |=> $stable(wb_adr))
    else $error("bus_master: address moved while waiting for ack");

endmodule

// File: src/core_control.sv
`timescale 1ns/1ns

module core_control (
  input  logic              clk,
  input  logic              reset,
  input  cpu_pkg::opcode_t  opcode,
  input  logic              done,
  output logic              req_fetch,
  output logic              req_data,
  output logic              data_we,
  output logic              ir_load,
  output logic              pc_load,
  output logic              rf_write,
  output logic              pixel_strobe,
  output logic              halt
);
  import cpu_pkg::*;

  state_t state;
  state_t state_next;
  logic   writes_reg;
  logic   is_mem;

  always_comb begin
    case (opcode)
      op_loadi, op_load, op_alu_hi, op_alu_lo, op_addi, op_subi, op_andi, op_ori: begin
        writes_reg = 1'b1;
      end
      default: writes_reg = 1'b0;  // op_coord lands here and does nothing
    endcase
  end

  assign is_mem = (opcode == op_load) || (opcode == op_store);

  always_comb begin
    state_next = state;
    case (state)
      st_fetch:     if (done) state_next = st_decode;
      st_decode:    state_next = st_execute;
      st_execute: begin
        if (opcode == op_halt) state_next = st_halted;
        else if (is_mem) state_next = st_memory;
        else state_next = st_writeback;
      end
      st_memory:    if (done) state_next = st_writeback;
      st_writeback: state_next = st_fetch;
      default:      state_next = st_halted;  // halted stays until reset
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) state <= st_fetch;
    else state <= state_next;
  end

  assign req_fetch    = (state == st_fetch);
  assign req_data     = (state == st_memory);
  assign data_we      = req_data && (opcode == op_store);
  assign ir_load      = req_fetch && done;
  assign pc_load      = (state == st_writeback);
  assign rf_write     = pc_load && writes_reg;
  assign pixel_strobe = (state == st_execute) && (opcode == op_pixel);  // one cycle only
  assign halt         = (state == st_halted);

  assert property (@(posedge clk) !(req_fetch && req_data))
    else $error("core_control: fetch and data requests overlap");

  assert property (@(posedge clk) (halt && !reset) |=> halt)
    else $error("core_control: halt dropped without reset");

endmodule

// File: src/cpu_pkg.sv
package cpu_pkg;

  localparam int addr_width = 16;  // memory word address
  localparam int data_width = 32;  // registers and bus data
  localparam int inst_width = 16;

  // top nibble of the instruction word
  typedef enum logic [3:0] {
    op_halt   = 4'b0000,
    op_branch = 4'b0010,
    op_jump   = 4'b0100,
    op_pixel  = 4'b0101,
    op_loadi  = 4'b0110,
    op_store  = 4'b0111,
    op_load   = 4'b1000,
    op_coord  = 4'b1001,  // decoded as a no-op
    op_alu_hi = 4'b1010,
    op_alu_lo = 4'b1011,
    op_addi   = 4'b1100,
    op_subi   = 4'b1101,
    op_andi   = 4'b1110,
    op_ori    = 4'b1111
  } opcode_t;

  // order matters, register ALU opcodes index this directly with funct
  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_and, alu_or,
    alu_xor, alu_shl, alu_shr, alu_slt,
    alu_mov, alu_nor, alu_sra, alu_nand,
    alu_xnor, alu_seq, alu_pass_a, alu_pass_b
  } alu_op_t;

  typedef enum logic [2:0] {
    st_fetch, st_decode, st_execute, st_memory, st_writeback, st_halted
  } state_t;

endpackage

// File: src/cpu_top.sv
`timescale 1ns/1ns

module cpu_top #(
  parameter logic [cpu_pkg::addr_width-1:0] reset_pc = '0,
  parameter int                             num_regs = 8
) (
  input  logic                            clk,
  input  logic                            reset,
  output logic                            wb_cyc,
  output logic                            wb_stb,
  output logic                            wb_we,
  output logic [cpu_pkg::addr_width-1:0]  wb_adr,
  output logic [cpu_pkg::data_width-1:0]  wb_dat_w,
  input  logic [cpu_pkg::data_width-1:0]  wb_dat_r,
  input  logic                            wb_ack,
  input  logic [1:0]                      sw,
  output logic [9:0]                      leds,
  output logic                            pixel_en,
  output logic                            pixel_value,
  output logic [31:0]                     pixel_addr,
  output logic                            halt
);
  import cpu_pkg::*;

  opcode_t               opcode;
  alu_op_t               alu_op;
  logic                  req_fetch, req_data, data_we, done;
  logic                  ir_load, pc_load, rf_write;
  logic                  use_imm, mem_read, mem_write, branch, jump, alu_zero;
  logic [addr_width-1:0] pc, pc_plus1;
  logic [inst_width-1:0] inst;
  logic [data_width-1:0] imm, reg1_data, reg2_data, store_data, alu_result, bus_rdata;

  wire [data_width-1:0] alu_b       = use_imm ? imm : reg2_data;
  wire                  take_branch = branch & ~alu_zero;  // rd nonzero
  wire [data_width-1:0] write_data  = mem_read ? bus_rdata : alu_result;

  assign pixel_addr = reg1_data;  // rs for the pixel opcode

  fetch #(.reset_pc(reset_pc)) i_fetch (
    .clk(clk), .reset(reset), .ir_load(ir_load), .pc_load(pc_load), .rdata(bus_rdata),
    .take_branch(take_branch), .is_jump(jump), .branch_offset(imm[addr_width-1:0]),
    .jump_target(imm[addr_width-1:0]), .pc(pc), .pc_plus1(pc_plus1), .inst(inst)
  );

  decode #(.num_regs(num_regs)) i_decode (
    .clk(clk), .reset(reset), .inst(inst), .pc_plus1(pc_plus1), .rf_write(rf_write),
    .write_data(write_data), .sw(sw), .opcode(opcode), .alu_op(alu_op), .use_imm(use_imm),
    .imm(imm), .reg1_data(reg1_data), .reg2_data(reg2_data), .store_data(store_data),
    .mem_read(mem_read), .mem_write(mem_write), .branch(branch), .jump(jump),
    .pixel_value(pixel_value), .leds(leds)
  );

  alu i_alu (.op(alu_op), .a(reg1_data), .b(alu_b), .result(alu_result), .zero(alu_zero));

  core_control i_core_control (
    .clk(clk), .reset(reset), .opcode(opcode), .done(done), .req_fetch(req_fetch),
    .req_data(req_data), .data_we(data_we), .ir_load(ir_load), .pc_load(pc_load),
    .rf_write(rf_write), .pixel_strobe(pixel_en), .halt(halt)
  );

  bus_master i_bus_master (
    .clk(clk), .reset(reset), .req_fetch(req_fetch), .req_data(req_data & (mem_read | mem_write)),
    .data_we(data_we), .pc(pc), .data_adr(alu_result[addr_width-1:0]), .wdata(store_data),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr), .wb_dat_w(wb_dat_w),
    .wb_dat_r(wb_dat_r), .wb_ack(wb_ack), .rdata(bus_rdata), .done(done)
  );

endmodule

// File: src/decode.sv
`timescale 1ns/1ns

module decode #(
  parameter int num_regs = 8
) (
  input  logic                            clk,
  input  logic                            reset,
  input  logic [cpu_pkg::inst_width-1:0]  inst,
  input  logic [cpu_pkg::addr_width-1:0]  pc_plus1,
  input  logic                            rf_write,
  input  logic [cpu_pkg::data_width-1:0]  write_data,
  input  logic [1:0]                      sw,
  output cpu_pkg::opcode_t                opcode,
  output cpu_pkg::alu_op_t                alu_op,
  output logic                            use_imm,
  output logic [cpu_pkg::data_width-1:0]  imm,
  output logic [cpu_pkg::data_width-1:0]  reg1_data,
  output logic [cpu_pkg::data_width-1:0]  reg2_data,
  output logic [cpu_pkg::data_width-1:0]  store_data,
  output logic                            mem_read,
  output logic                            mem_write,
  output logic                            branch,
  output logic                            jump,
  output logic                            pixel_value,
  output logic [9:0]                      leds
);
  import cpu_pkg::*;

  localparam int reg_bits = $clog2(num_regs);

  logic [reg_bits-1:0]   rd, rs, rq;
  logic [2:0]            funct;
  logic [data_width-1:0] rs_data, rq_data, rd_data;
  logic                  rd_is_base;

  assign opcode = opcode_t'(inst[15:12]);
  assign rd     = inst[9 +: reg_bits];
  assign rs     = inst[6 +: reg_bits];
  assign rq     = inst[3 +: reg_bits];
  assign funct  = inst[2:0];

  reg_file #(.num_regs(num_regs)) i_reg_file (
    .clk        (clk),
    .reset      (reset),
    .read1_reg  (rs),
    .read2_reg  (rq),
    .read3_reg  (rd),
    .write_reg  (rd),
    .write_en   (rf_write),
    .write_data (write_data),
    .sw         (sw),
    .read1_data (rs_data),
    .read2_data (rq_data),
    .read3_data (rd_data),
    .leds       (leds)
  );

  // immediate ALU ops, stores and branches work on rd, everything else on rs
  assign rd_is_base = (opcode inside {op_addi, op_subi, op_andi, op_ori, op_store, op_branch});
  assign reg1_data  = rd_is_base ? rd_data : rs_data;
  assign reg2_data  = rq_data;
  assign store_data = rq_data;

  assign use_imm = (opcode inside {op_addi, op_subi, op_andi, op_ori, op_loadi, op_load,
                                   op_store});

  always_comb begin
    imm    = '0;
    alu_op = alu_pass_b;
    case (opcode)
      op_addi: begin
        imm    = {{(data_width-6){inst[5]}}, inst[5:0]};
        alu_op = alu_add;
      end
      op_load, op_store: begin
        imm    = {{(data_width-6){1'b0}}, inst[5:0]};  // word offset from the base register
        alu_op = alu_add;
      end
      op_subi: begin
        imm    = {{(data_width-6){inst[5]}}, inst[5:0]};
        alu_op = alu_sub;
      end
      op_andi: begin
        imm    = {{(data_width-6){inst[5]}}, inst[5:0]};
        alu_op = alu_and;
      end
      op_ori: begin
        imm    = {{(data_width-6){inst[5]}}, inst[5:0]};
        alu_op = alu_or;
      end
      op_loadi:  imm = {{(data_width-9){1'b0}}, inst[8:0]};
      op_jump:   imm = {{(data_width-12){1'b0}}, inst[11:0]};
      op_branch: begin
        imm    = {{(data_width-9){inst[8]}}, inst[8:0]};
        alu_op = alu_pass_a;  // zero flag then tells whether rd is zero
      end
      op_pixel:  alu_op = alu_pass_a;
      op_alu_lo: alu_op = (funct == 3'd0) ? alu_mov : alu_op_t'({1'b0, funct});
      op_alu_hi: alu_op = alu_op_t'({1'b1, funct});
      default: ;  // halt and the dropped coordinate read
    endcase
  end

  assign mem_read    = (opcode == op_load);
  assign mem_write   = (opcode == op_store);
  assign branch      = (opcode == op_branch);
  assign jump        = (opcode == op_jump);
  assign pixel_value = inst[0];

  assert property (@(posedge clk) disable iff (reset) !(mem_read && mem_write))
    else $error("decode: load and store decoded together");

  // a new instruction word never arrives in the cycle the PC advances
  assert property (@(posedge clk) disable iff (reset) $changed(inst) |-> $stable(pc_plus1))
    else $error("decode: PC and instruction register moved together");

endmodule

// File: src/fetch.sv
`timescale 1ns/1ns

module fetch #(
  parameter logic [cpu_pkg::addr_width-1:0] reset_pc = '0
) (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            ir_load,
  input  logic                            pc_load,
  input  logic [cpu_pkg::data_width-1:0]  rdata,
  input  logic                            take_branch,
  input  logic                            is_jump,
  input  logic [cpu_pkg::addr_width-1:0]  branch_offset,
  input  logic [cpu_pkg::addr_width-1:0]  jump_target,
  output logic [cpu_pkg::addr_width-1:0]  pc,
  output logic [cpu_pkg::addr_width-1:0]  pc_plus1,
  output logic [cpu_pkg::inst_width-1:0]  inst
);
  import cpu_pkg::*;

  logic [addr_width-1:0] next_pc;

  assign pc_plus1 = pc + 1'b1;

  always_comb begin
    if (is_jump) next_pc = jump_target;
    else if (take_branch) next_pc = pc_plus1 + branch_offset;  // relative to the next word
    else next_pc = pc_plus1;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc   <= reset_pc;
      inst <= '0;
    end else begin
      if (pc_load) pc <= next_pc;  // once per instruction, in writeback
      if (ir_load) inst <= rdata[inst_width-1:0];  // instruction sits in the low half
    end
  end

endmodule

// File: src/reg_file.sv
`timescale 1ns/1ns

module reg_file #(
  parameter int num_regs = 8
) (
  input  logic                            clk,
  input  logic                            reset,
  input  logic [$clog2(num_regs)-1:0]     read1_reg,
  input  logic [$clog2(num_regs)-1:0]     read2_reg,
  input  logic [$clog2(num_regs)-1:0]     read3_reg,
  input  logic [$clog2(num_regs)-1:0]     write_reg,
  input  logic                            write_en,
  input  logic [cpu_pkg::data_width-1:0]  write_data,
  input  logic [1:0]                      sw,
  output logic [cpu_pkg::data_width-1:0]  read1_data,
  output logic [cpu_pkg::data_width-1:0]  read2_data,
  output logic [cpu_pkg::data_width-1:0]  read3_data,
  output logic [9:0]                      leds
);
  import cpu_pkg::*;

  logic [data_width-1:0] regs [num_regs];
  logic [data_width-1:0] sw_word;

  // register 0 has no storage of its own, it shows the switches
  assign sw_word = {{(data_width-2){1'b0}}, sw};

  assign read1_data = (read1_reg == '0) ? sw_word : regs[read1_reg];
  assign read2_data = (read2_reg == '0) ? sw_word : regs[read2_reg];
  assign read3_data = (read3_reg == '0) ? sw_word : regs[read3_reg];

  assign leds = regs[num_regs-1][9:0];  // top register drives the LEDs

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (write_en && write_reg != '0) begin  // writes to r0 are dropped
      regs[write_reg] <= write_data;
    end
  end

endmodule
